/* hdl/glb_consts.svh */
// ~~~~~~~~~~~~~~~~~~~~
// geometry of one global buffer tile
// address = {tile, bank, word}, tile field on top
// ~~~~~~~~~~~~~~~~~~~~
`ifndef GLB_CONSTS_SVH
`define GLB_CONSTS_SVH

`define GLB_BANKS_PER_TILE  4
`define GLB_BANK_SEL_WIDTH  2
`define GLB_BANK_ADDR_WIDTH 6
`define GLB_TILE_SEL_WIDTH  2

// full request address width
`define GLB_ADDR_WIDTH (`GLB_TILE_SEL_WIDTH + `GLB_BANK_SEL_WIDTH + `GLB_BANK_ADDR_WIDTH)

`define GLB_DATA_WIDTH 16

`endif

/* hdl/glb_packet_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// packet formats on the core channels
// an all-zero packet is idle, no handshake
// ~~~~~~~~~~~~~~~~~~~~
`include "glb_consts.svh"

package glb_packet_pkg;

    // write packet
    typedef struct packed {
        logic                       wr_en;
        logic [`GLB_ADDR_WIDTH-1:0] wr_addr;
        logic [`GLB_DATA_WIDTH-1:0] wr_data;
    } wr_packet_t;

    // read request
    typedef struct packed {
        logic                       rd_en;
        logic [`GLB_ADDR_WIDTH-1:0] rd_addr;
    } rdrq_packet_t;

    // read response, data counts only with valid set
    typedef struct packed {
        logic [`GLB_DATA_WIDTH-1:0] rd_data;
        logic                       rd_data_valid;
    } rdrs_packet_t;

endpackage

/* hdl/glb_cfg_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// tile configuration as seen by the switch
// DMA modes are static while traffic runs
// ~~~~~~~~~~~~~~~~~~~~
package glb_cfg_pkg;

    // DMA mode settings, nonzero or one means on
    typedef struct packed {
        logic [1:0] st_dma_mode;
        logic [1:0] ld_dma_mode;
        logic       pc_dma_mode;
    } glb_cfg_t;

    // which source a tile read was issued for
    typedef enum logic [2:0] {
        NONE     = 3'd0,
        PROC     = 3'd1,
        STRM_DMA = 3'd2,
        STRM_RTR = 3'd3,
        PC_DMA   = 3'd4,
        PC_RTR   = 3'd5
    } rdrq_src_t;

endpackage

/* hdl/glb_bank.sv */
// ~~~~~~~~~~~~~~~~~~~~
// one bank, single-cycle registered read
// only the word field of the address is decoded
// read and write of one word in one cycle returns the old data
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "glb_consts.svh"

module glb_bank (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         clk_en,
    input  glb_packet_pkg::wr_packet_t   wr_packet,
    input  glb_packet_pkg::rdrq_packet_t rdrq_packet,
    output glb_packet_pkg::rdrs_packet_t rdrs_packet
);

    logic [`GLB_DATA_WIDTH-1:0]      mem [2**`GLB_BANK_ADDR_WIDTH];
    logic [`GLB_BANK_ADDR_WIDTH-1:0] wr_word;
    logic [`GLB_BANK_ADDR_WIDTH-1:0] rd_word;

    assign wr_word = wr_packet.wr_addr[`GLB_BANK_ADDR_WIDTH-1:0];
    assign rd_word = rdrq_packet.rd_addr[`GLB_BANK_ADDR_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (clk_en && wr_packet.wr_en) begin
            mem[wr_word] <= wr_packet.wr_data;
        end
    end

    // response is idle zero unless a read was taken
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rdrs_packet <= '0;
        end else if (clk_en) begin
            rdrs_packet.rd_data_valid <= rdrq_packet.rd_en;
            if (rdrq_packet.rd_en) begin
                rdrs_packet.rd_data <= mem[rd_word];
            end else begin
                rdrs_packet.rd_data <= '0;
            end
        end
    end

endmodule

/* hdl/glb_core_switch.sv */
// ~~~~~~~~~~~~~~~~~~~~
// core channel switch of one tile
// one write and one read per cycle, losers are dropped
// tile reads come back three enabled edges after issue
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "glb_consts.svh"

module glb_core_switch (
    input  logic                             clk,
    input  logic                             clk_en,
    input  logic                             reset,
    input  logic [`GLB_TILE_SEL_WIDTH-1:0]   glb_tile_id,
    input  glb_cfg_pkg::glb_cfg_t            cfg,

    input  glb_packet_pkg::wr_packet_t       wr_packet_proc,
    input  glb_packet_pkg::wr_packet_t       wr_packet_dma,
    input  glb_packet_pkg::wr_packet_t       wr_packet_rtr,
    output glb_packet_pkg::wr_packet_t       wr_packet_rtr_out,
    output glb_packet_pkg::wr_packet_t       wr_packet_bank [`GLB_BANKS_PER_TILE],

    input  glb_packet_pkg::rdrq_packet_t     rdrq_packet_proc,
    input  glb_packet_pkg::rdrq_packet_t     rdrq_packet_st_dma,
    input  glb_packet_pkg::rdrq_packet_t     rdrq_packet_st_rtr,
    input  glb_packet_pkg::rdrq_packet_t     rdrq_packet_pc_dma,
    input  glb_packet_pkg::rdrq_packet_t     rdrq_packet_pc_rtr,
    output glb_packet_pkg::rdrq_packet_t     rdrq_packet_st_rtr_out,
    output glb_packet_pkg::rdrq_packet_t     rdrq_packet_pc_rtr_out,
    output glb_packet_pkg::rdrq_packet_t     rdrq_packet_bank [`GLB_BANKS_PER_TILE],

    input  glb_packet_pkg::rdrs_packet_t     rdrs_packet_st_rtr,
    input  glb_packet_pkg::rdrs_packet_t     rdrs_packet_pc_rtr,
    output glb_packet_pkg::rdrs_packet_t     rdrs_packet_proc,
    output glb_packet_pkg::rdrs_packet_t     rdrs_packet_st_dma,
    output glb_packet_pkg::rdrs_packet_t     rdrs_packet_st_rtr_out,
    output glb_packet_pkg::rdrs_packet_t     rdrs_packet_pc_dma,
    output glb_packet_pkg::rdrs_packet_t     rdrs_packet_pc_rtr_out,
    input  glb_packet_pkg::rdrs_packet_t     rdrs_packet_bank [`GLB_BANKS_PER_TILE]
);

    import glb_packet_pkg::*;
    import glb_cfg_pkg::*;

    // read tag follows a tile read down the pipeline
    typedef struct packed {
        rdrq_src_t                      src;
        logic [`GLB_BANK_SEL_WIDTH-1:0] bank;
    } rd_tag_t;

    localparam rd_tag_t tag_idle = '{src: NONE, bank: '0};

    logic                           st_dma_on;
    logic                           ld_dma_on;
    logic                           pc_dma_on;
    wr_packet_t                     wr_muxed;
    wr_packet_t                     wr_filtered;
    wr_packet_t                     wr_d1;
    logic [`GLB_BANK_SEL_WIDTH-1:0] wr_bank_sel;
    rdrq_src_t                      rd_src;
    rdrq_packet_t                   rdrq_muxed;
    rdrq_packet_t                   rdrq_d1;
    rd_tag_t                        rd_tag;
    rd_tag_t                        rd_tag_d1;
    rd_tag_t                        rd_tag_d2;
    rd_tag_t                        rd_tag_d3;
    rdrs_packet_t                   rdrs_bank_d1 [`GLB_BANKS_PER_TILE];
    rdrs_packet_t                   rdrs_hit;

    function automatic logic tile_match(input logic [`GLB_ADDR_WIDTH-1:0] addr,
                                        input logic [`GLB_TILE_SEL_WIDTH-1:0] tile_id);
        return addr[`GLB_ADDR_WIDTH-1 -: `GLB_TILE_SEL_WIDTH] == tile_id;
    endfunction

    assign st_dma_on = (cfg.st_dma_mode != 2'b00);
    assign ld_dma_on = (cfg.ld_dma_mode != 2'b00);
    assign pc_dma_on = (cfg.pc_dma_mode == 1'b1);

    // write: proc first, then stream DMA or stream router
    always_comb begin
        if (wr_packet_proc.wr_en) begin
            wr_muxed = wr_packet_proc;
        end else if (st_dma_on) begin
            wr_muxed = wr_packet_dma;
        end else begin
            wr_muxed = wr_packet_rtr;
        end
        wr_filtered = tile_match(wr_muxed.wr_addr, glb_tile_id) ? wr_muxed : '0;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_d1 <= '0;
        end else if (clk_en) begin
            wr_d1 <= wr_filtered;
        end
    end

    assign wr_bank_sel = wr_d1.wr_addr[`GLB_BANK_ADDR_WIDTH +: `GLB_BANK_SEL_WIDTH];

    always_comb begin
        for (int i = 0; i < `GLB_BANKS_PER_TILE; i++) begin
            wr_packet_bank[i] = (wr_bank_sel == i) ? wr_d1 : '0;
        end
    end

    // read arbitration, only requests for this tile compete
    always_comb begin
        if (rdrq_packet_proc.rd_en && tile_match(rdrq_packet_proc.rd_addr, glb_tile_id)) begin
            rd_src = PROC;
        end else if (pc_dma_on && rdrq_packet_pc_dma.rd_en &&
                     tile_match(rdrq_packet_pc_dma.rd_addr, glb_tile_id)) begin
            rd_src = PC_DMA;
        end else if (!pc_dma_on && rdrq_packet_pc_rtr.rd_en &&
                     tile_match(rdrq_packet_pc_rtr.rd_addr, glb_tile_id)) begin
            rd_src = PC_RTR;
        end else if (ld_dma_on && rdrq_packet_st_dma.rd_en &&
                     tile_match(rdrq_packet_st_dma.rd_addr, glb_tile_id)) begin
            rd_src = STRM_DMA;
        end else if (!ld_dma_on && rdrq_packet_st_rtr.rd_en &&
                     tile_match(rdrq_packet_st_rtr.rd_addr, glb_tile_id)) begin
            rd_src = STRM_RTR;
        end else begin
            rd_src = NONE;
        end
    end

    always_comb begin
        case (rd_src)
            PROC:     rdrq_muxed = rdrq_packet_proc;
            STRM_DMA: rdrq_muxed = rdrq_packet_st_dma;
            STRM_RTR: rdrq_muxed = rdrq_packet_st_rtr;
            PC_DMA:   rdrq_muxed = rdrq_packet_pc_dma;
            PC_RTR:   rdrq_muxed = rdrq_packet_pc_rtr;
            default:  rdrq_muxed = '0;
        endcase
        rd_tag.src  = rd_src;
        rd_tag.bank = rdrq_muxed.rd_addr[`GLB_BANK_ADDR_WIDTH +: `GLB_BANK_SEL_WIDTH];
    end

    // d1 goes with the request, d2 with bank data, d3 with the registered response
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rdrq_d1   <= '0;
            rd_tag_d1 <= tag_idle;
            rd_tag_d2 <= tag_idle;
            rd_tag_d3 <= tag_idle;
        end else if (clk_en) begin
            rdrq_d1   <= rdrq_muxed;
            rd_tag_d1 <= rd_tag;
            rd_tag_d2 <= rd_tag_d1;
            rd_tag_d3 <= rd_tag_d2;
        end
    end

    always_comb begin
        for (int i = 0; i < `GLB_BANKS_PER_TILE; i++) begin
            rdrq_packet_bank[i] = (rd_tag_d1.bank == i) ? rdrq_d1 : '0;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `GLB_BANKS_PER_TILE; i++) begin
                rdrs_bank_d1[i] <= '0;
            end
        end else if (clk_en) begin
            for (int i = 0; i < `GLB_BANKS_PER_TILE; i++) begin
                rdrs_bank_d1[i] <= rdrs_packet_bank[i];
            end
        end
    end

    assign rdrs_hit = rdrs_bank_d1[rd_tag_d3.bank];

    // chain forwarding
    assign wr_packet_rtr_out      = st_dma_on ? wr_packet_dma : wr_packet_rtr;
    assign rdrq_packet_st_rtr_out = ld_dma_on ? rdrq_packet_st_dma : rdrq_packet_st_rtr;
    assign rdrq_packet_pc_rtr_out = pc_dma_on ? rdrq_packet_pc_dma : rdrq_packet_pc_rtr;

    // tile response wins over upstream traffic on the same output
    always_comb begin
        rdrs_packet_proc       = '0;
        rdrs_packet_st_dma     = ld_dma_on ? rdrs_packet_st_rtr : '0;
        rdrs_packet_st_rtr_out = ld_dma_on ? '0 : rdrs_packet_st_rtr;
        rdrs_packet_pc_dma     = pc_dma_on ? rdrs_packet_pc_rtr : '0;
        rdrs_packet_pc_rtr_out = pc_dma_on ? '0 : rdrs_packet_pc_rtr;
        case (rd_tag_d3.src)
            PROC:     rdrs_packet_proc       = rdrs_hit;
            STRM_DMA: rdrs_packet_st_dma     = rdrs_hit;
            STRM_RTR: rdrs_packet_st_rtr_out = rdrs_hit;
            PC_DMA:   rdrs_packet_pc_dma     = rdrs_hit;
            PC_RTR:   rdrs_packet_pc_rtr_out = rdrs_hit;
            default: begin
            end
        endcase
    end

endmodule

/* hdl/glb_tile.sv */
// ~~~~~~~~~~~~~~~~~~~~
// one global buffer tile, switch plus bank array
// no timing beyond that of the switch and banks
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "glb_consts.svh"

module glb_tile (
    input  logic                           clk,
    input  logic                           clk_en,
    input  logic                           reset,
    input  logic [`GLB_TILE_SEL_WIDTH-1:0] glb_tile_id,
    input  glb_cfg_pkg::glb_cfg_t          cfg,

    input  glb_packet_pkg::wr_packet_t     wr_packet_proc,
    input  glb_packet_pkg::wr_packet_t     wr_packet_dma,
    input  glb_packet_pkg::wr_packet_t     wr_packet_rtr,
    output glb_packet_pkg::wr_packet_t     wr_packet_rtr_out,

    input  glb_packet_pkg::rdrq_packet_t   rdrq_packet_proc,
    input  glb_packet_pkg::rdrq_packet_t   rdrq_packet_st_dma,
    input  glb_packet_pkg::rdrq_packet_t   rdrq_packet_st_rtr,
    input  glb_packet_pkg::rdrq_packet_t   rdrq_packet_pc_dma,
    input  glb_packet_pkg::rdrq_packet_t   rdrq_packet_pc_rtr,
    output glb_packet_pkg::rdrq_packet_t   rdrq_packet_st_rtr_out,
    output glb_packet_pkg::rdrq_packet_t   rdrq_packet_pc_rtr_out,

    input  glb_packet_pkg::rdrs_packet_t   rdrs_packet_st_rtr,
    input  glb_packet_pkg::rdrs_packet_t   rdrs_packet_pc_rtr,
    output glb_packet_pkg::rdrs_packet_t   rdrs_packet_proc,
    output glb_packet_pkg::rdrs_packet_t   rdrs_packet_st_dma,
    output glb_packet_pkg::rdrs_packet_t   rdrs_packet_st_rtr_out,
    output glb_packet_pkg::rdrs_packet_t   rdrs_packet_pc_dma,
    output glb_packet_pkg::rdrs_packet_t   rdrs_packet_pc_rtr_out
);

    import glb_packet_pkg::*;

    wr_packet_t   wr_packet_bank   [`GLB_BANKS_PER_TILE];
    rdrq_packet_t rdrq_packet_bank [`GLB_BANKS_PER_TILE];
    rdrs_packet_t rdrs_packet_bank [`GLB_BANKS_PER_TILE];

    glb_core_switch u_core_switch (
        .clk                    (clk),
        .clk_en                 (clk_en),
        .reset                  (reset),
        .glb_tile_id            (glb_tile_id),
        .cfg                    (cfg),
        .wr_packet_proc         (wr_packet_proc),
        .wr_packet_dma          (wr_packet_dma),
        .wr_packet_rtr          (wr_packet_rtr),
        .wr_packet_rtr_out      (wr_packet_rtr_out),
        .wr_packet_bank         (wr_packet_bank),
        .rdrq_packet_proc       (rdrq_packet_proc),
        .rdrq_packet_st_dma     (rdrq_packet_st_dma),
        .rdrq_packet_st_rtr     (rdrq_packet_st_rtr),
        .rdrq_packet_pc_dma     (rdrq_packet_pc_dma),
        .rdrq_packet_pc_rtr     (rdrq_packet_pc_rtr),
        .rdrq_packet_st_rtr_out (rdrq_packet_st_rtr_out),
        .rdrq_packet_pc_rtr_out (rdrq_packet_pc_rtr_out),
        .rdrq_packet_bank       (rdrq_packet_bank),
        .rdrs_packet_st_rtr     (rdrs_packet_st_rtr),
        .rdrs_packet_pc_rtr     (rdrs_packet_pc_rtr),
        .rdrs_packet_proc       (rdrs_packet_proc),
        .rdrs_packet_st_dma     (rdrs_packet_st_dma),
        .rdrs_packet_st_rtr_out (rdrs_packet_st_rtr_out),
        .rdrs_packet_pc_dma     (rdrs_packet_pc_dma),
        .rdrs_packet_pc_rtr_out (rdrs_packet_pc_rtr_out),
        .rdrs_packet_bank       (rdrs_packet_bank)
    );

    // bank array
    for (genvar i = 0; i < `GLB_BANKS_PER_TILE; i++) begin : bank_gen
        glb_bank u_bank (
            .clk         (clk),
            .reset       (reset),
            .clk_en      (clk_en),
            .wr_packet   (wr_packet_bank[i]),
            .rdrq_packet (rdrq_packet_bank[i]),
            .rdrs_packet (rdrs_packet_bank[i])
        );
    end

endmodule

/* bench/glb_switch_properties.sv */
// ~~~~~~~~~~~~~~~~~~~~
// assertions bound into every glb_core_switch
// proc timing check relies on proc reads always winning arbitration
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "glb_consts.svh"

module glb_switch_properties (
    input logic                           clk,
    input logic                           reset,
    input logic                           clk_en,
    input logic [`GLB_TILE_SEL_WIDTH-1:0] glb_tile_id,
    input glb_packet_pkg::wr_packet_t     wr_packet_bank [`GLB_BANKS_PER_TILE],
    input glb_packet_pkg::rdrq_packet_t   rdrq_packet_bank [`GLB_BANKS_PER_TILE],
    input glb_packet_pkg::rdrq_packet_t   rdrq_packet_proc,
    input glb_packet_pkg::rdrs_packet_t   rdrs_packet_proc
);

    logic [`GLB_BANKS_PER_TILE-1:0] wr_en_vec;
    logic [`GLB_BANKS_PER_TILE-1:0] rd_en_vec;
    logic                           bank_busy;
    logic                           proc_hit;
    logic [2:0]                     proc_hist;
    int                             assert_fails = 0;

    always_comb begin
        bank_busy = 1'b0;
        for (int i = 0; i < `GLB_BANKS_PER_TILE; i++) begin
            wr_en_vec[i] = wr_packet_bank[i].wr_en;
            rd_en_vec[i] = rdrq_packet_bank[i].rd_en;
            bank_busy = bank_busy | (|wr_packet_bank[i]) | (|rdrq_packet_bank[i]);
        end
    end

    assign proc_hit = rdrq_packet_proc.rd_en &&
        (rdrq_packet_proc.rd_addr[`GLB_ADDR_WIDTH-1 -: `GLB_TILE_SEL_WIDTH] == glb_tile_id);

    // proc tile reads seen at the last three enabled edges
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            proc_hist <= '0;
        end else if (clk_en) begin
            proc_hist <= {proc_hist[1:0], proc_hit};
        end
    end

    assert property (@(posedge clk) disable iff (reset) $onehot0(wr_en_vec))
        else begin
            $error("more than one bank write enable is high");
            assert_fails++;
        end

    assert property (@(posedge clk) disable iff (reset) $onehot0(rd_en_vec))
        else begin
            $error("more than one bank read enable is high");
            assert_fails++;
        end

    assert property (@(posedge clk) disable iff (reset)
                     rdrs_packet_proc.rd_data_valid |-> proc_hist[2])
        else begin
            $error("proc response valid without a proc read three enabled edges before");
            assert_fails++;
        end

    assert property (@(posedge clk) reset |-> !bank_busy)
        else begin
            $error("bank packet not idle during reset");
            assert_fails++;
        end

endmodule

bind glb_core_switch glb_switch_properties u_switch_properties (
    .clk              (clk),
    .reset            (reset),
    .clk_en           (clk_en),
    .glb_tile_id      (glb_tile_id),
    .wr_packet_bank   (wr_packet_bank),
    .rdrq_packet_bank (rdrq_packet_bank),
    .rdrq_packet_proc (rdrq_packet_proc),
    .rdrs_packet_proc (rdrs_packet_proc)
);

/* bench/glb_tile_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~
// testbench for glb_tile, tile id 1 except in the foreign tile test
// every word of the tile is written before the first read
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "glb_consts.svh"

module glb_tile_tb;

    import glb_packet_pkg::*;
    import glb_cfg_pkg::*;

    localparam int word_bits  = `GLB_ADDR_WIDTH - `GLB_TILE_SEL_WIDTH;
    // stimulus takes about 800 cycles
    localparam int max_cycles = 1500;

    // expected tile response, one per enabled edge
    typedef struct packed {
        rdrq_src_t                  src;
        logic [`GLB_DATA_WIDTH-1:0] data;
    } exp_rd_t;

    logic                           clk = 1'b0;
    logic                           reset;
    logic                           clk_en;
    logic [`GLB_TILE_SEL_WIDTH-1:0] glb_tile_id;
    glb_cfg_t                       cfg;
    wr_packet_t   wr_packet_proc, wr_packet_dma, wr_packet_rtr, wr_packet_rtr_out;
    rdrq_packet_t rdrq_packet_proc, rdrq_packet_st_dma, rdrq_packet_st_rtr;
    rdrq_packet_t rdrq_packet_pc_dma, rdrq_packet_pc_rtr;
    rdrq_packet_t rdrq_packet_st_rtr_out, rdrq_packet_pc_rtr_out;
    rdrs_packet_t rdrs_packet_st_rtr, rdrs_packet_pc_rtr, rdrs_packet_proc;
    rdrs_packet_t rdrs_packet_st_dma, rdrs_packet_st_rtr_out;
    rdrs_packet_t rdrs_packet_pc_dma, rdrs_packet_pc_rtr_out;

    logic [`GLB_DATA_WIDTH-1:0] ref_mem [2**`GLB_ADDR_WIDTH];
    exp_rd_t                    exp_q [$];
    logic [31:0]                rng;
    int                         errors = 0;
    int                         checks = 0;
    int                         cycle_cnt = 0;

    glb_tile uut (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            $display("timeout: test did not finish within %0d cycles", max_cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic read_for_tile(input rdrq_packet_t p,
                                           input logic [`GLB_TILE_SEL_WIDTH-1:0] tile);
        return p.rd_en && (p.rd_addr[`GLB_ADDR_WIDTH-1 -: `GLB_TILE_SEL_WIDTH] == tile);
    endfunction

    // proc, then PC DMA or router, then stream DMA or router
    function automatic rdrq_src_t expect_src(input rdrq_packet_t proc, st_dma, st_rtr,
                                             input rdrq_packet_t pc_dma, pc_rtr,
                                             input glb_cfg_t c,
                                             input logic [`GLB_TILE_SEL_WIDTH-1:0] tile);
        if (read_for_tile(proc, tile)) begin
            return PROC;
        end
        if (c.pc_dma_mode == 1'b1 && read_for_tile(pc_dma, tile)) begin
            return PC_DMA;
        end
        if (c.pc_dma_mode == 1'b0 && read_for_tile(pc_rtr, tile)) begin
            return PC_RTR;
        end
        if (c.ld_dma_mode != 2'b00 && read_for_tile(st_dma, tile)) begin
            return STRM_DMA;
        end
        if (c.ld_dma_mode == 2'b00 && read_for_tile(st_rtr, tile)) begin
            return STRM_RTR;
        end
        return NONE;
    endfunction

    task automatic check_rdrs(input string what, input rdrs_packet_t got,
                              input rdrs_packet_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] t=%0d ns %s: got data %h valid %b, expected data %h valid %b",
                     $time, what, got.rd_data, got.rd_data_valid, exp.rd_data,
                     exp.rd_data_valid);
        end
    endtask

    task automatic check_wr(input string what, input wr_packet_t got, input wr_packet_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] t=%0d ns %s: got en %b addr %h data %h, expected %b %h %h",
                     $time, what, got.wr_en, got.wr_addr, got.wr_data, exp.wr_en,
                     exp.wr_addr, exp.wr_data);
        end
    endtask

    task automatic check_rdrq(input string what, input rdrq_packet_t got,
                              input rdrq_packet_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] t=%0d ns %s: got en %b addr %h, expected en %b addr %h",
                     $time, what, got.rd_en, got.rd_addr, exp.rd_en, exp.rd_addr);
        end
    endtask

    // reference model, takes the inputs at each enabled edge
    always @(posedge clk) begin : ref_model
        exp_rd_t    e;
        wr_packet_t w;
        if (reset) begin
            exp_q.delete();
        end else if (clk_en) begin
            e.src = expect_src(rdrq_packet_proc, rdrq_packet_st_dma, rdrq_packet_st_rtr,
                               rdrq_packet_pc_dma, rdrq_packet_pc_rtr, cfg, glb_tile_id);
            case (e.src)
                PROC:     e.data = ref_mem[rdrq_packet_proc.rd_addr];
                STRM_DMA: e.data = ref_mem[rdrq_packet_st_dma.rd_addr];
                STRM_RTR: e.data = ref_mem[rdrq_packet_st_rtr.rd_addr];
                PC_DMA:   e.data = ref_mem[rdrq_packet_pc_dma.rd_addr];
                PC_RTR:   e.data = ref_mem[rdrq_packet_pc_rtr.rd_addr];
                default:  e.data = '0;
            endcase
            // a write lands after a read of the same edge
            if (wr_packet_proc.wr_en) begin
                w = wr_packet_proc;
            end else if (cfg.st_dma_mode != 2'b00) begin
                w = wr_packet_dma;
            end else begin
                w = wr_packet_rtr;
            end
            if (w.wr_en && w.wr_addr[`GLB_ADDR_WIDTH-1 -: `GLB_TILE_SEL_WIDTH] == glb_tile_id) begin
                ref_mem[w.wr_addr] = w.wr_data;
            end
            exp_q.push_back(e);
            if (exp_q.size() > 3) begin
                void'(exp_q.pop_front());
            end
        end
    end

    // outputs settle well before the falling edge
    always @(negedge clk) begin : compare_outputs
        exp_rd_t      head;
        rdrs_packet_t hit;
        rdrs_packet_t e_proc, e_st_dma, e_st_out, e_pc_dma, e_pc_out;
        if (!reset) begin
            head.src  = NONE;
            head.data = '0;
            if (exp_q.size() == 3) begin
                head = exp_q[0];
            end
            hit.rd_data       = head.data;
            hit.rd_data_valid = 1'b1;
            e_proc   = '0;
            e_st_dma = (cfg.ld_dma_mode != 2'b00) ? rdrs_packet_st_rtr : '0;
            e_st_out = (cfg.ld_dma_mode != 2'b00) ? '0 : rdrs_packet_st_rtr;
            e_pc_dma = cfg.pc_dma_mode ? rdrs_packet_pc_rtr : '0;
            e_pc_out = cfg.pc_dma_mode ? '0 : rdrs_packet_pc_rtr;
            case (head.src)
                PROC:     e_proc   = hit;
                STRM_DMA: e_st_dma = hit;
                STRM_RTR: e_st_out = hit;
                PC_DMA:   e_pc_dma = hit;
                PC_RTR:   e_pc_out = hit;
                default: begin
                end
            endcase
            check_rdrs("proc response", rdrs_packet_proc, e_proc);
            check_rdrs("stream dma response", rdrs_packet_st_dma, e_st_dma);
            check_rdrs("stream chain response", rdrs_packet_st_rtr_out, e_st_out);
            check_rdrs("pc dma response", rdrs_packet_pc_dma, e_pc_dma);
            check_rdrs("pc chain response", rdrs_packet_pc_rtr_out, e_pc_out);
            check_wr("stream chain write", wr_packet_rtr_out,
                     (cfg.st_dma_mode != 2'b00) ? wr_packet_dma : wr_packet_rtr);
            check_rdrq("stream chain read", rdrq_packet_st_rtr_out,
                       (cfg.ld_dma_mode != 2'b00) ? rdrq_packet_st_dma : rdrq_packet_st_rtr);
            check_rdrq("pc chain read", rdrq_packet_pc_rtr_out,
                       cfg.pc_dma_mode ? rdrq_packet_pc_dma : rdrq_packet_pc_rtr);
        end
    end

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic clear_inputs();
        wr_packet_proc     = '0;
        wr_packet_dma      = '0;
        wr_packet_rtr      = '0;
        rdrq_packet_proc   = '0;
        rdrq_packet_st_dma = '0;
        rdrq_packet_st_rtr = '0;
        rdrq_packet_pc_dma = '0;
        rdrq_packet_pc_rtr = '0;
        rdrs_packet_st_rtr = '0;
        rdrs_packet_pc_rtr = '0;
    endtask

    // mostly this tile, or never this tile when foreign is set
    function automatic logic [`GLB_TILE_SEL_WIDTH-1:0] pick_tile(input logic [31:0] r,
                                                                 input logic foreign);
        logic [1:0] flip;
        flip = (r[1:0] == 2'b00) ? 2'b01 : r[1:0];
        if (foreign || r[3:2] == 2'b00) begin
            return glb_tile_id ^ flip;
        end
        return glb_tile_id;
    endfunction

    task automatic rand_wr(output wr_packet_t p, input logic foreign);
        rng       = xorshift32(rng);
        p.wr_en   = rng[4] & (rng[5] | rng[6]);
        p.wr_addr = {pick_tile(rng, foreign), rng[word_bits+5:6]};
        p.wr_data = rng[31:16];
    endtask

    task automatic rand_rdrq(output rdrq_packet_t p, input logic foreign);
        rng       = xorshift32(rng);
        p.rd_en   = rng[4] | rng[5];
        p.rd_addr = {pick_tile(rng, foreign), rng[word_bits+5:6]};
    endtask

    task automatic rand_rdrs(output rdrs_packet_t p);
        rng             = xorshift32(rng);
        p.rd_data       = rng[31:16];
        p.rd_data_valid = rng[0];
    endtask

    task automatic random_traffic(input int n, input logic foreign);
        repeat (n) begin
            rand_wr(wr_packet_proc, foreign);
            rand_wr(wr_packet_dma, foreign);
            rand_wr(wr_packet_rtr, foreign);
            rand_rdrq(rdrq_packet_proc, foreign);
            rand_rdrq(rdrq_packet_st_dma, foreign);
            rand_rdrq(rdrq_packet_st_rtr, foreign);
            rand_rdrq(rdrq_packet_pc_dma, foreign);
            rand_rdrq(rdrq_packet_pc_rtr, foreign);
            rand_rdrs(rdrs_packet_st_rtr);
            rand_rdrs(rdrs_packet_pc_rtr);
            tick();
        end
        clear_inputs();
    endtask

    task automatic fill_tile();
        for (int a = 0; a < 2**word_bits; a++) begin
            rng = xorshift32(rng);
            wr_packet_proc = '{wr_en: 1'b1, wr_addr: {glb_tile_id, a[word_bits-1:0]},
                               wr_data: rng[15:0]};
            tick();
        end
        clear_inputs();
    endtask

    task automatic proc_reads(input int n);
        repeat (n) begin
            rng = xorshift32(rng);
            rdrq_packet_proc = '{rd_en: 1'b1, rd_addr: {glb_tile_id, rng[word_bits-1:0]}};
            tick();
        end
        clear_inputs();
    endtask

    // clk_en drops gap cycles after the read, a read offered meanwhile is ignored
    task automatic stalled_read(input int gap, input int stall);
        proc_reads(1);
        repeat (gap) tick();
        clk_en = 1'b0;
        rng = xorshift32(rng);
        rdrq_packet_proc = '{rd_en: 1'b1, rd_addr: {glb_tile_id, rng[word_bits-1:0]}};
        repeat (stall) tick();
        clear_inputs();
        clk_en = 1'b1;
        repeat (4) tick();
    endtask

    initial begin
        clear_inputs();
        reset       = 1'b1;
        clk_en      = 1'b1;
        glb_tile_id = 2'd1;
        cfg         = '0;
        rng         = 32'hdd66;
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;
        fill_tile();
        proc_reads(64);
        // foreign traffic under two tile ids, then read back
        random_traffic(40, 1'b1);
        glb_tile_id = 2'd2;
        random_traffic(40, 1'b1);
        glb_tile_id = 2'd1;
        proc_reads(32);
        for (int m = 0; m < 8; m++) begin
            cfg.pc_dma_mode = m[0];
            cfg.ld_dma_mode = m[1] ? 2'b10 : 2'b00;
            cfg.st_dma_mode = m[2] ? 2'b11 : 2'b00;
            random_traffic(30, 1'b0);
            random_traffic(10, 1'b1);
        end
        cfg = '0;
        for (int g = 0; g < 3; g++) begin
            stalled_read(g, 3 + g);
        end
        repeat (4) tick();
        errors = errors + uut.u_core_switch.u_switch_properties.assert_fails;
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
                 uut.u_core_switch.u_switch_properties.assert_fails);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+hdl
hdl/glb_packet_pkg.sv
hdl/glb_cfg_pkg.sv
hdl/glb_bank.sv
hdl/glb_core_switch.sv
hdl/glb_tile.sv
bench/glb_switch_properties.sv
bench/glb_tile_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module glb_tile_tb || exit 1
sim_out=$(./obj_dir/Vglb_tile_tb)
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -q "TESTS PASSED" && exit 0 || exit 1
